//--- project.f
+incdir+src
src/cp0Pkg.sv
src/cp0CommitIf.sv
src/excCommit.sv
src/cp0Regs.sv
src/excRedirect.sv
src/cp0Top.sv
verif/cp0Tb.sv

//--- Bender.yml
package:
  name: cp0

sources:
  - include_dirs:
      - src
    files:
      - src/cp0Pkg.sv
      - src/cp0CommitIf.sv
      - src/excCommit.sv
      - src/cp0Regs.sv
      - src/excRedirect.sv
      - src/cp0Top.sv
  - target: test
    include_dirs:
      - src
    files:
      - verif/cp0Tb.sv

//--- verif/cp0Tb.sv
//********************************************************************
// Self-checking testbench for the CP0 top level. A shadow model
// predicts registers and redirects; a negedge process checks flushes.
//********************************************************************
`timescale 1ns/1ps
`include "cp0_cfg.svh"

module cp0Tb import cp0Pkg::*; ();

    localparam word_t STATUS_WMASK = 32'h0000_FF03; // IM, EXL, IE
    localparam word_t CAUSE_WMASK  = 32'h0000_0300; // IP1..IP0
    localparam word_t CAUSE_CHK    = 32'h8000_037C; // BD, IP1..0, ExcCode

    logic     clk, rst, commitValid, commitDelaySlot, commitEret, mtc0We;
    logic     flush, timerIrq;
    word_t    commitPc, commitBadAddr, mtc0Data, rdData, flushPc;
    excVec_t  commitExc;
    regAddr_t mtc0Addr, rdAddr;
    hwInt_t   hwInt;

    word_t  mStatus, mCause, mEpc, mBad, mCompare; // shadow registers
    logic   mFlush;
    logic   flushArmed;
    word_t  expPc, epcRead, cntBase, rndExc;
    integer edgeCnt = 0;
    integer flushDue, cntEdge, valErrs, otherErrs, seed, n;
    string  testName;

    cp0Top i_cp0Top (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) edgeCnt <= edgeCnt + 1;

    task automatic reportMismatch(input string what, input word_t exp, input word_t act);
        valErrs++;
        $display("[FAIL] %s %s expected %h actual %h", testName, what, exp, act);
    endtask

    //****************************************************************
    // reference model that updates the shadow copies
    // returns the expected redirect pc and sets mFlush when one is due
    //****************************************************************
    function automatic word_t cp0Model(input logic wr, input regAddr_t addr, input word_t data,
            input excVec_t exc, input word_t pc, input logic ds, input word_t bad,
            input logic eret);
        integer   i;
        integer   top;
        logic     pend;
        logic     badWe;
        excCode_t code;
        mFlush = 1'b0;
        if (wr) begin
            case (addr)
                `CP0_REG_STATUS:  mStatus = (mStatus & ~STATUS_WMASK) | (data & STATUS_WMASK);
                `CP0_REG_CAUSE:   mCause = (mCause & ~CAUSE_WMASK) | (data & CAUSE_WMASK);
                `CP0_REG_EPC:     mEpc = data;
                `CP0_REG_COMPARE: mCompare = data;
                default: ;
            endcase
            return mEpc;
        end
        pend = (|({hwInt, mCause[9:8]} & mStatus[15:8])) && mStatus[`STATUS_IE]
             && !mStatus[`STATUS_EXL];
        if (!pend && exc == '0) begin
            mFlush = eret;
            if (eret) mStatus[`STATUS_EXL] = 1'b0;
            return mEpc; // return address is the old EPC
        end
        top = 7; // 7 means interrupt
        if (!pend) begin
            for (i = 6; i >= 0; i--) begin
                if (exc[i]) top = i; // lowest index wins
            end
        end
        badWe = (top == FetchAddr) || (top == StoreAddr) || (top == LoadAddr);
        case (top)
            FetchAddr, LoadAddr: code = `EXC_ADEL;
            ReservedInst:        code = `EXC_RI;
            Syscall:             code = `EXC_SYS;
            Break:               code = `EXC_BP;
            Overflow:            code = `EXC_OV;
            StoreAddr:           code = `EXC_ADES;
            default:             code = `EXC_INT;
        endcase
        mFlush = 1'b1;
        if (!mStatus[`STATUS_EXL]) begin
            mEpc = ds ? pc - 32'd4 : pc;
            mCause[`CAUSE_BD] = ds;
        end
        mStatus[`STATUS_EXL] = 1'b1;
        mCause[6:2] = code;
        if (badWe) mBad = (top == FetchAddr) ? pc : bad;
        return `EXC_VECTOR;
    endfunction

    //****************************************************************
    // flush checker with its window two edges after the commit edge
    //****************************************************************
    always @(negedge clk) begin
        if (rst === 1'b1) begin
            if (flush && !(flushArmed && edgeCnt == flushDue)) begin
                otherErrs++;
                $display("%s: flush raised outside the expected window", testName);
            end else if (flush) begin
                if (flushPc !== expPc) reportMismatch("flushPc", expPc, flushPc);
            end else if (flushArmed && edgeCnt == flushDue) begin
                otherErrs++;
                $display("%s: flush missing two edges after the commit", testName);
            end
        end
    end

    task automatic writeReg(input regAddr_t addr, input word_t data);
        word_t ignored;
        @(negedge clk);
        mtc0We   = 1'b1;
        mtc0Addr = addr;
        mtc0Data = data;
        ignored  = cp0Model(1'b1, addr, data, '0, '0, 1'b0, '0, 1'b0);
        @(negedge clk);
        mtc0We = 1'b0;
        if (addr == `CP0_REG_COUNT) begin
            cntBase = data; // count phase restarts here
            cntEdge = edgeCnt;
        end
    endtask

    task automatic checkReg(input string what, input regAddr_t addr, input word_t exp,
            input word_t mask);
        @(negedge clk);
        rdAddr = addr;
        #1;
        if ((rdData & mask) !== (exp & mask)) reportMismatch(what, exp & mask, rdData & mask);
    endtask

    task automatic checkCount();
        word_t exp;
        @(negedge clk);
        rdAddr = `CP0_REG_COUNT;
        #1;
        exp = cntBase + (edgeCnt - cntEdge) / 2; // one step per two edges
        if (rdData !== exp) reportMismatch("Count", exp, rdData);
    endtask

    task automatic checkShadow();
        checkReg("Status", `CP0_REG_STATUS, mStatus, '1);
        checkReg("Cause", `CP0_REG_CAUSE, mCause, CAUSE_CHK);
        checkReg("EPC", `CP0_REG_EPC, mEpc, '1);
        checkReg("BadVAddr", `CP0_REG_BADVADDR, mBad, '1);
    endtask

    task automatic commitInstr(input excVec_t exc, input word_t pc, input logic ds,
            input word_t bad, input logic eret);
        integer k;
        @(negedge clk);
        commitValid     = 1'b1;
        commitExc       = exc;
        commitPc        = pc;
        commitDelaySlot = ds;
        commitBadAddr   = bad;
        commitEret      = eret;
        expPc      <= cp0Model(1'b0, '0, '0, exc, pc, ds, bad, eret);
        flushArmed <= mFlush;
        flushDue   <= edgeCnt + 2;
        @(negedge clk);
        commitValid = 1'b0;
        commitExc   = '0;
        commitEret  = 1'b0;
        k = 0;
        while (mFlush && !flush && k < 6) begin
            @(negedge clk);
            k++;
        end
        if (mFlush && !flush) begin
            otherErrs++;
            $display("%s: no flush within 6 cycles of the commit", testName);
        end
        repeat (3) @(negedge clk); // keep commits spaced
    endtask

    initial begin
        seed = 32'h1b1c;
        {rst, commitValid, commitDelaySlot, commitEret, mtc0We} = '0;
        {commitPc, commitBadAddr, mtc0Data} = '0;
        commitExc = '0;
        mtc0Addr  = '0;
        rdAddr    = '0;
        hwInt     = '0;
        mStatus   = `STATUS_RESET;
        {mCause, mEpc, mBad, mCompare, expPc} = '0;
        flushArmed = 1'b0;
        flushDue   = 0;
        valErrs    = 0;
        otherErrs  = 0;
        testName   = "reset";
        repeat (8) @(negedge clk);
        rst     = 1'b1;
        cntBase = '0;
        cntEdge = edgeCnt;

        // reset values and write masks
        checkShadow();
        checkReg("Cause", `CP0_REG_CAUSE, '0, '1); // TI and IP bits too
        checkCount();
        checkReg("Compare", `CP0_REG_COMPARE, '0, '1);
        checkReg("unimplemented", 5'd3, '0, '1);
        testName = "masks";
        repeat (6) begin
            writeReg(`CP0_REG_STATUS, $random(seed));
            writeReg(`CP0_REG_CAUSE, $random(seed));
            writeReg(`CP0_REG_EPC, $random(seed));
            writeReg(`CP0_REG_COMPARE, $random(seed));
            checkShadow();
            checkReg("Compare", `CP0_REG_COMPARE, mCompare, '1);
        end
        writeReg(`CP0_REG_STATUS, '0);
        writeReg(`CP0_REG_CAUSE, '0);
        writeReg(`CP0_REG_COMPARE, '0);

        // priority with random flag vectors
        testName = "priority";
        for (n = 0; n < 14; n++) begin
            writeReg(`CP0_REG_STATUS, '0);
            rndExc = ($random(seed) | 32'h1) << (n % 7); // flag n % 7 is the top one
            commitInstr(rndExc[6:0], $random(seed) & 32'hFFFF_FFFC, 1'b0, $random(seed), 1'b0);
            checkShadow();
        end

        // delay slot, then a nested exception
        testName = "delay slot";
        writeReg(`CP0_REG_STATUS, '0);
        commitInstr(7'b1 << Syscall, 32'h0000_0400, 1'b1, '0, 1'b0);
        checkShadow();
        checkReg("EPC after delay slot", `CP0_REG_EPC, 32'h0000_03FC, '1);
        commitInstr(7'b1 << Break, 32'h0000_0800, 1'b0, '0, 1'b0);
        checkShadow();
        checkReg("EPC after nested", `CP0_REG_EPC, 32'h0000_03FC, '1);

        // eret returns to EPC and drops EXL
        testName = "eret";
        @(negedge clk);
        rdAddr = `CP0_REG_EPC;
        #1;
        epcRead = rdData;
        commitInstr('0, 32'h0000_0900, 1'b0, '0, 1'b1);
        if (flushPc !== epcRead) reportMismatch("eret target", epcRead, flushPc);
        checkReg("Status.EXL", `CP0_REG_STATUS, '0, 32'h1 << `STATUS_EXL);

        // timer
        testName = "timer";
        writeReg(`CP0_REG_COMPARE, 32'h0000_1006);
        writeReg(`CP0_REG_COUNT, 32'h0000_1000);
        checkCount();
        checkCount();
        checkCount();
        n = 0;
        while (!timerIrq && n < 40) begin
            @(negedge clk);
            n++;
        end
        if (!timerIrq) begin
            otherErrs++;
            $display("%s: timerIrq never rose after Count reached Compare", testName);
        end else if (rdData !== mCompare) begin
            reportMismatch("Count at timerIrq", mCompare, rdData);
        end
        writeReg(`CP0_REG_COMPARE, '0);
        if (timerIrq !== 1'b0) reportMismatch("timerIrq after Compare write", '0, timerIrq);

        // hardware interrupt on IP4, then masked by IE
        testName = "interrupt";
        @(negedge clk);
        hwInt = 6'b000100;
        writeReg(`CP0_REG_STATUS, 32'h0000_1001);
        commitInstr('0, 32'h0000_2000, 1'b0, '0, 1'b0);
        checkShadow();
        checkReg("ExcCode", `CP0_REG_CAUSE, {25'b0, `EXC_INT, 2'b0}, 32'h7C);
        commitInstr('0, 32'h0000_2000, 1'b0, '0, 1'b1);
        writeReg(`CP0_REG_STATUS, 32'h0000_1000);
        commitInstr('0, 32'h0000_2004, 1'b0, '0, 1'b0);
        checkShadow();
        @(negedge clk);
        hwInt = '0;

        $display("value errors: %0d, other errors: %0d", valErrs, otherErrs);
        if (valErrs + otherErrs == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

//--- src/cp0Top.sv
//********************************************************************
// CP0 top level. Commit logic, register file and redirect logic
// joined by the commit event bus; the pipeline sees plain ports.
//********************************************************************
`timescale 1ns/1ps
`include "cp0_cfg.svh"

module cp0Top import cp0Pkg::*; (
    input  logic     clk,
    input  logic     rst,
    // writeback commit
    input  logic     commitValid,
    input  word_t    commitPc,
    input  logic     commitDelaySlot,
    input  word_t    commitBadAddr,
    input  excVec_t  commitExc,
    input  logic     commitEret,
    // mtc0 / mfc0
    input  logic     mtc0We,
    input  regAddr_t mtc0Addr,
    input  word_t    mtc0Data,
    input  regAddr_t rdAddr,
    output word_t    rdData,
    input  hwInt_t   hwInt,
    // pipeline redirect
    output logic     flush,
    output word_t    flushPc,
    output logic     timerIrq
);

    word_t status;
    word_t cause;
    word_t epc;

    cp0CommitIf commitBus ();

    assign timerIrq = cause[`CAUSE_TI]; // to the interrupt controller

    excCommit i_excCommit (
        .clk(clk), .rst(rst),
        .commitValid(commitValid), .commitPc(commitPc),
        .commitDelaySlot(commitDelaySlot), .commitBadAddr(commitBadAddr),
        .commitExc(commitExc), .commitEret(commitEret),
        .status(status), .cause(cause),
        .bus(commitBus.commit)
    );

    cp0Regs i_cp0Regs (
        .clk(clk), .rst(rst), .hwInt(hwInt),
        .mtc0We(mtc0We), .mtc0Addr(mtc0Addr), .mtc0Data(mtc0Data),
        .rdAddr(rdAddr), .rdData(rdData),
        .status(status), .cause(cause), .epc(epc),
        .bus(commitBus.regs)
    );

    excRedirect i_excRedirect (
        .clk(clk), .rst(rst), .epc(epc),
        .flush(flush), .flushPc(flushPc),
        .bus(commitBus.redirect)
    );

endmodule

//--- src/excRedirect.sv
//********************************************************************
// Output side of CP0. Turns a taken exception or eret into a
// one-cycle pipeline flush with the fetch redirect address.
//********************************************************************
`timescale 1ns/1ps
`include "cp0_cfg.svh"

module excRedirect import cp0Pkg::*; (
    input  logic         clk,
    input  logic         rst,
    input  word_t        epc,
    output logic         flush,
    output word_t        flushPc,
    cp0CommitIf.redirect bus
);

    logic  redirectNext;
    word_t pcNext;

    assign redirectNext = bus.excTake | bus.eretTake;

    // eret returns to EPC as held before this edge
    assign pcNext = bus.excTake ? `EXC_VECTOR : epc;

    // flush strobe
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            flush <= 1'b0;
        end else begin
            flush <= redirectNext;
        end
    end

    // redirect target, held between flushes
    always_ff @(posedge clk) begin
        if (redirectNext) begin
            flushPc <= pcNext;
        end
    end

endmodule

//--- src/cp0Regs.sv
//********************************************************************
// CP0 register file: BadVAddr, Count, Compare, Status, Cause, EPC.
// Handles the timer, mtc0 writes and exception/eret updates, and
// serves mfc0 reads through a combinational mux.
//********************************************************************
`timescale 1ns/1ps
`include "cp0_cfg.svh"

module cp0Regs import cp0Pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  hwInt_t   hwInt,
    input  logic     mtc0We,
    input  regAddr_t mtc0Addr,
    input  word_t    mtc0Data,
    input  regAddr_t rdAddr,
    output word_t    rdData,
    output word_t    status,
    output word_t    cause,
    output word_t    epc,
    cp0CommitIf.regs bus
);

    word_t badVaddr;
    word_t count;
    word_t compare;
    logic  countPhase; // high on the edge that bumps Count
    logic  countWr;
    logic  timerHit;

    assign countWr  = mtc0We && (mtc0Addr == `CP0_REG_COUNT);
    assign timerHit = (compare != '0) && (count == compare);

    //****************************************************************
    // register update
    //****************************************************************
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            badVaddr   <= '0;
            count      <= '0;
            compare    <= '0;
            status     <= `STATUS_RESET;
            cause      <= '0;
            epc        <= '0;
            countPhase <= 1'b0;
        end else begin
            // IP7..IP2 follow the pins, timer folded into IP7
            cause[15:10] <= {hwInt[5] | cause[`CAUSE_TI], hwInt[4:0]};

            // half-rate count, a write restarts the phase
            if (countWr) begin
                countPhase <= 1'b0;
            end else begin
                countPhase <= ~countPhase;
                if (countPhase) begin
                    count <= count + 32'd1;
                end
            end

            if (timerHit) begin
                cause[`CAUSE_TI] <= 1'b1; // sticky until Compare written
            end

            // software writes, masked per register
            if (mtc0We) begin
                case (mtc0Addr)
                    `CP0_REG_COUNT: begin
                        count <= mtc0Data;
                    end
                    `CP0_REG_COMPARE: begin
                        compare          <= mtc0Data;
                        cause[`CAUSE_TI] <= 1'b0; // acknowledges the timer
                    end
                    `CP0_REG_STATUS: begin
                        status[15:8]        <= mtc0Data[15:8]; // IM
                        status[`STATUS_EXL] <= mtc0Data[`STATUS_EXL];
                        status[`STATUS_IE]  <= mtc0Data[`STATUS_IE];
                    end
                    `CP0_REG_CAUSE: begin
                        cause[9:8] <= mtc0Data[9:8]; // software interrupts only
                    end
                    `CP0_REG_EPC: begin
                        epc <= mtc0Data;
                    end
                    default: begin
                    end
                endcase
            end

            //********************************************************
            // exception entry and return
            // placed last so an event wins over a same-edge mtc0
            //********************************************************
            if (bus.excTake) begin
                // nested exception keeps the original return point
                if (!status[`STATUS_EXL]) begin
                    epc             <= bus.excEpc;
                    cause[`CAUSE_BD] <= bus.excBd;
                end
                status[`STATUS_EXL] <= 1'b1;
                cause[6:2]          <= bus.excCode;
                if (bus.badVaddrWe) begin
                    badVaddr <= bus.badVaddr;
                end
            end else if (bus.eretTake) begin
                status[`STATUS_EXL] <= 1'b0;
            end
        end
    end

    //****************************************************************
    // mfc0 read mux
    //****************************************************************
    always_comb begin
        case (rdAddr)
            `CP0_REG_BADVADDR: rdData = badVaddr;
            `CP0_REG_COUNT:    rdData = count;
            `CP0_REG_COMPARE:  rdData = compare;
            `CP0_REG_STATUS:   rdData = status;
            `CP0_REG_CAUSE:    rdData = cause;
            `CP0_REG_EPC:      rdData = epc;
            default:           rdData = '0; // unimplemented numbers
        endcase
    end

endmodule

//--- src/excCommit.sv
//********************************************************************
// Commit side of CP0. Samples the instruction retired by writeback,
// picks the one exception to take (interrupts first) and drives
// the event strobes one cycle later.
//********************************************************************
`timescale 1ns/1ps
`include "cp0_cfg.svh"

module excCommit import cp0Pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       commitValid,
    input  word_t      commitPc,
    input  logic       commitDelaySlot,
    input  word_t      commitBadAddr,
    input  excVec_t    commitExc,
    input  logic       commitEret,
    input  word_t      status,
    input  word_t      cause,
    cp0CommitIf.commit bus
);

    logic     intPending;
    logic     takeNext;
    logic     eretNext;
    logic     badWeNext;
    excCode_t codeNext;
    word_t    badNext;
    word_t    epcNext;

    // IP & IM, only while IE=1 and EXL=0
    assign intPending = (|(cause[15:8] & status[15:8]))
                      & status[`STATUS_IE] & ~status[`STATUS_EXL];

    assign takeNext = commitValid & (intPending | (|commitExc));
    assign eretNext = commitValid & commitEret & ~takeNext; // eret dropped if excepting
    assign epcNext  = commitDelaySlot ? commitPc - 32'd4 : commitPc;

    //****************************************************************
    // priority select
    //****************************************************************
    always_comb begin
        codeNext  = `EXC_INT;
        badWeNext = 1'b0;
        badNext   = commitBadAddr;
        if (intPending) begin
            codeNext = `EXC_INT; // interrupt beats the instruction's own flags
        end else if (commitExc[FetchAddr]) begin
            codeNext  = `EXC_ADEL;
            badWeNext = 1'b1;
            badNext   = commitPc; // the fetch address itself was bad
        end else if (commitExc[ReservedInst]) begin
            codeNext = `EXC_RI;
        end else if (commitExc[Syscall]) begin
            codeNext = `EXC_SYS;
        end else if (commitExc[Break]) begin
            codeNext = `EXC_BP;
        end else if (commitExc[Overflow]) begin
            codeNext = `EXC_OV;
        end else if (commitExc[StoreAddr]) begin
            codeNext  = `EXC_ADES;
            badWeNext = 1'b1;
        end else if (commitExc[LoadAddr]) begin
            codeNext  = `EXC_ADEL;
            badWeNext = 1'b1;
        end
    end

    // event strobes
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            bus.excTake    <= 1'b0;
            bus.eretTake   <= 1'b0;
            bus.badVaddrWe <= 1'b0;
        end else begin
            bus.excTake    <= takeNext;
            bus.eretTake   <= eretNext;
            bus.badVaddrWe <= takeNext & badWeNext;
        end
    end

    // event payload, only meaningful with excTake
    always_ff @(posedge clk) begin
        if (takeNext) begin
            bus.excCode  <= codeNext;
            bus.excEpc   <= epcNext;
            bus.excBd    <= commitDelaySlot;
            bus.badVaddr <= badNext;
        end
    end

endmodule

//--- src/cp0CommitIf.sv
//********************************************************************
// One decided CP0 event, passed from the commit logic to the
// register file and to the redirect logic. Strobes last one cycle.
//********************************************************************
`timescale 1ns/1ps

interface cp0CommitIf import cp0Pkg::*; ();

    logic     excTake;    // exception or interrupt taken
    excCode_t excCode;
    word_t    excEpc;     // restart pc, delay slot already handled
    logic     excBd;      // branch delay flag
    logic     badVaddrWe;
    word_t    badVaddr;
    logic     eretTake;   // never together with excTake

    modport commit (
        output excTake, excCode, excEpc, excBd,
        output badVaddrWe, badVaddr, eretTake
    );

    modport regs (
        input excTake, excCode, excEpc, excBd,
        input badVaddrWe, badVaddr, eretTake
    );

    modport redirect (
        input excTake, eretTake
    );

endinterface

//--- src/cp0Pkg.sv
//********************************************************************
// Shared types of the CP0 block. Modules pull these in with a
// wildcard import in their header.
//********************************************************************
package cp0Pkg;

    // widths with architectural meaning
    typedef logic [31:0] word_t;    // data word or address
    typedef logic [4:0]  regAddr_t; // CP0 register number
    typedef logic [4:0]  excCode_t; // Cause.ExcCode
    typedef logic [6:0]  excVec_t;  // raw exception flags, see excIdx_e
    typedef logic [5:0]  hwInt_t;   // external interrupt levels

    //****************************************************************
    // bit positions inside excVec_t
    // listed from highest to lowest priority
    //****************************************************************
    typedef enum logic [2:0] {
        FetchAddr    = 3'd0, // fetch address error
        ReservedInst = 3'd1,
        Syscall      = 3'd2,
        Break        = 3'd3,
        Overflow     = 3'd4,
        StoreAddr    = 3'd5, // data address error on store
        LoadAddr     = 3'd6  // data address error on load
    } excIdx_e;

endpackage

//--- src/cp0_cfg.svh
//********************************************************************
// CP0 configuration constants: register numbers, exception vector,
// Status reset value and the bit positions of the control fields.
// Include wherever one of these values is needed.
//********************************************************************
`ifndef CP0_CFG_SVH
`define CP0_CFG_SVH

// register numbers on the mtc0 / mfc0 ports
`define CP0_REG_BADVADDR  5'd8
`define CP0_REG_COUNT     5'd9
`define CP0_REG_COMPARE   5'd11
`define CP0_REG_STATUS    5'd12
`define CP0_REG_CAUSE     5'd13
`define CP0_REG_EPC       5'd14

// handler entry, BEV=1 general exception vector
`define EXC_VECTOR        32'hBFC00380

// only BEV set out of reset
`define STATUS_RESET      32'h0040_0000

// Cause.ExcCode values
`define EXC_INT           5'd0
`define EXC_ADEL          5'd4
`define EXC_ADES          5'd5
`define EXC_SYS           5'd8
`define EXC_BP            5'd9
`define EXC_RI            5'd10
`define EXC_OV            5'd12

// single-bit fields
`define STATUS_EXL        1
`define STATUS_IE         0
`define CAUSE_BD          31
`define CAUSE_TI          30

`endif
